// ==== sim.f ====
+incdir+.
safety_pkg.sv
axis_sample_if.sv
current_sampler.sv
current_safety_check.sv
amp_disable_ctrl.sv
safety_top.sv
safety_checker.sv
tb_safety_top.sv

// ==== Makefile ====
# simulation of the motor amplifier safety supervisor with Verilator
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_safety_top
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides pass or fail, not the exit status of the model
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== safety_tests.txt ====
# cmd: cur|dac <axis> <hex value>, en|clr <hex axis mask>, wait <cycles>
# check <test> <amp_disable hex> <first_fault_valid> <first_fault, ignored when valid is 0>
check 1 0 0 0
en f
dac 0 a000
cur 0 a400
dac 1 a000
cur 1 a400
dac 2 a000
cur 2 a400
dac 3 a000
cur 3 a400
wait 10
check 2 0 0 0
# axis 2 beyond the margin, then axis 0
cur 2 c000
wait 10
check 3 4 1 2
cur 0 c000
wait 10
check 4 5 1 2
# near-zero measurement, command at the range ends, enable low
cur 1 8100
dac 1 9000
wait 10
check 5 5 1 2
dac 3 f6ff
wait 10
check 6 5 1 2
dac 3 0900
wait 10
check 7 5 1 2
en d
cur 1 c000
wait 10
check 8 5 1 2
# short violation on axis 3 ends before the limit
dac 3 a000
cur 3 c000
wait 3
cur 3 a400
wait 10
check 9 5 1 2
# release axis 2, then axis 0
cur 2 a400
clr 4
clr 0
check 10 1 1 2
cur 0 a400
clr 1
clr 0
check 11 0 0 0
# clear held over a live violation on axis 1, then let go
clr 2
en f
wait 10
check 12 0 0 0
clr 0
wait 3
check 13 2 1 1

// ==== tb_safety_top.sv ====
`include "safety_defs.svh"

module tb_safety_top;

    localparam string TESTS_FILE = "safety_tests.txt";

    logic                  clk = 1'b0;
    logic                  rst;
    safety_pkg::current_t  cur_in;
    logic                  cur_stb;
    safety_pkg::current_t  dac_in;
    logic                  dac_stb;
    safety_pkg::axis_t     axis_sel;
    logic [`NUM_AXES-1:0]  enable_check;
    logic [`NUM_AXES-1:0]  clear_disable;
    logic [`NUM_AXES-1:0]  amp_disable;
    logic                  any_disable;
    safety_pkg::axis_t     first_fault;
    logic                  first_fault_valid;

    // expected values for the checker
    logic                  chk_stb;
    int                    exp_test;
    logic [`NUM_AXES-1:0]  exp_dis;
    logic                  exp_ffv;
    safety_pkg::axis_t     exp_ff;
    logic                  tests_done;
    int                    pass_cnt;
    int                    fail_cnt;

    int                    file_errs   = 0; // unreadable lines in tests file
    int                    cycle_cnt   = 0;
    int                    cycle_limit = 0; // set once the file is scanned

    always #2 clk = ~clk; // period 4

    safety_top u_safety_top (
        .clk               (clk),
        .rst               (rst),
        .cur_in            (cur_in),
        .cur_stb           (cur_stb),
        .dac_in            (dac_in),
        .dac_stb           (dac_stb),
        .axis_sel          (axis_sel),
        .enable_check      (enable_check),
        .clear_disable     (clear_disable),
        .amp_disable       (amp_disable),
        .any_disable       (any_disable),
        .first_fault       (first_fault),
        .first_fault_valid (first_fault_valid)
    );

    safety_checker u_checker (
        .clk               (clk),
        .chk_stb           (chk_stb),
        .test_num          (exp_test),
        .exp_dis           (exp_dis),
        .exp_ffv           (exp_ffv),
        .exp_ff            (exp_ff),
        .tests_done        (tests_done),
        .amp_disable       (amp_disable),
        .any_disable       (any_disable),
        .first_fault       (first_fault),
        .first_fault_valid (first_fault_valid),
        .pass_cnt          (pass_cnt),
        .fail_cnt          (fail_cnt)
    );

    // run limit, summed waits plus 20 cycles per command
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic note_bad_line(input logic [63:0] tok);
        $display("tests file: cannot read line starting with '%0s'", tok);
        file_errs++;
    endtask

    task automatic scan_tests(input int fd, output int limit);
        int r;
        int n;
        int cmds;
        int waits;
        logic [63:0] tok;
        logic [8*128-1:0] rest;
        cmds  = 0;
        waits = 0;
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1) break;
            if (tok == "wait") begin
                r = $fscanf(fd, "%d", n);
                waits += n;
                cmds++;
            end else begin
                if (tok != "#") cmds++;
                r = $fgets(rest, fd); // skip rest of line
            end
        end
        limit = waits + 20 * cmds;
    endtask

    // one command per line, each takes one clock except wait
    task automatic run_tests(input int fd);
        int r;
        int axis;
        int n;
        int ffv;
        int ff;
        safety_pkg::current_t val;
        logic [`NUM_AXES-1:0] mask;
        logic [63:0] tok;
        logic [8*128-1:0] rest;
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1) break;
            if (tok == "#") begin
                r = $fgets(rest, fd);
            end else if (tok == "cur" || tok == "dac") begin
                r = $fscanf(fd, "%d %h", axis, val);
                if (r != 2) note_bad_line(tok);
                axis_sel = safety_pkg::axis_t'(axis);
                if (tok == "cur") begin
                    cur_in  = val;
                    cur_stb = 1'b1;
                end else begin
                    dac_in  = val;
                    dac_stb = 1'b1;
                end
                @(negedge clk);
                cur_stb = 1'b0;
                dac_stb = 1'b0;
            end else if (tok == "en" || tok == "clr") begin
                r = $fscanf(fd, "%h", mask);
                if (r != 1) note_bad_line(tok);
                if (tok == "en") begin
                    enable_check = mask;
                end else begin
                    clear_disable = mask; // level, held until next clr
                end
                @(negedge clk);
            end else if (tok == "wait") begin
                r = $fscanf(fd, "%d", n);
                if (r != 1) note_bad_line(tok);
                repeat (n) @(negedge clk);
            end else if (tok == "check") begin
                r = $fscanf(fd, "%d %h %d %d", exp_test, exp_dis, ffv, ff);
                if (r != 4) note_bad_line(tok);
                exp_ffv = ffv[0];
                exp_ff  = safety_pkg::axis_t'(ff);
                chk_stb = 1'b1;
                @(negedge clk);
                chk_stb = 1'b0;
            end else begin
                note_bad_line(tok);
                r = $fgets(rest, fd);
            end
        end
    endtask

    initial begin
        int fd;
        rst           = 1'b1;
        cur_in        = 16'h8000;
        cur_stb       = 1'b0;
        dac_in        = 16'h8000;
        dac_stb       = 1'b0;
        axis_sel      = '0;
        enable_check  = '0;
        clear_disable = '0;
        chk_stb       = 1'b0;
        exp_test      = 0;
        exp_dis       = '0;
        exp_ffv       = 1'b0;
        exp_ff        = '0;
        tests_done    = 1'b0;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("cannot open tests file %s", TESTS_FILE);
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            scan_tests(fd, cycle_limit);
            $fclose(fd);
            repeat (3) @(negedge clk); // 3 reset cycles
            rst = 1'b0;
            fd = $fopen(TESTS_FILE, "r");
            run_tests(fd);
            $fclose(fd);
            tests_done = 1'b1;
            @(negedge clk); // let the checker print its counts
            if (fail_cnt == 0 && file_errs == 0 && pass_cnt > 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== safety_checker.sv ====
`include "safety_defs.svh"

module safety_checker (
    input  logic                  clk,
    input  logic                  chk_stb,          // one cycle per check line
    input  int                    test_num,
    input  logic [`NUM_AXES-1:0]  exp_dis,
    input  logic                  exp_ffv,
    input  safety_pkg::axis_t     exp_ff,           // ignored while exp_ffv low
    input  logic                  tests_done,
    input  logic [`NUM_AXES-1:0]  amp_disable,
    input  logic                  any_disable,
    input  safety_pkg::axis_t     first_fault,
    input  logic                  first_fault_valid,
    output int                    pass_cnt,
    output int                    fail_cnt
);

    int   n_pass   = 0;
    int   n_fail   = 0;
    int   errs     = 0;    // mismatches in the current test
    logic reported = 1'b0;

    assign pass_cnt = n_pass;
    assign fail_cnt = n_fail;

    task automatic compare_value(input string name, input logic [15:0] expv,
                                 input logic [15:0] actv);
        if (actv !== expv) begin
            $display("error at %0t: %s expected %h got %h", $time, name, expv, actv);
            errs++;
        end
    endtask

    // sampled at posedge, dut outputs still hold the pre-edge state
    always @(posedge clk) begin
        if (chk_stb) begin
            errs = 0;
            compare_value("amp_disable", 16'(exp_dis), 16'(amp_disable));
            compare_value("any_disable", 16'(|exp_dis), 16'(any_disable)); // or of all latches
            compare_value("first_fault_valid", 16'(exp_ffv), 16'(first_fault_valid));
            if (exp_ffv) begin
                compare_value("first_fault", 16'(exp_ff), 16'(first_fault));
            end
            if (errs == 0) begin
                n_pass++;
                $display("test %0d passed", test_num);
            end else begin
                n_fail++;
                $display("test %0d failed, %0d mismatches", test_num, errs);
            end
        end
        if (tests_done && !reported) begin
            $display("checks done: %0d passed, %0d failed", n_pass, n_fail);
            reported = 1'b1; // only once
        end
    end

endmodule

// ==== safety_top.sv ====
`include "safety_defs.svh"

module safety_top (
    input  logic                   clk,
    input  logic                   rst,
    input  safety_pkg::current_t   cur_in,          // measured, from ADC side
    input  logic                   cur_stb,
    input  safety_pkg::current_t   dac_in,          // commanded, from DAC side
    input  logic                   dac_stb,
    input  safety_pkg::axis_t      axis_sel,
    input  logic [`NUM_AXES-1:0]   enable_check,
    input  logic [`NUM_AXES-1:0]   clear_disable,
    output logic [`NUM_AXES-1:0]   amp_disable,
    output logic                   any_disable,
    output safety_pkg::axis_t      first_fault,
    output logic                   first_fault_valid
);

    logic [`NUM_AXES-1:0] trip; // counter at limit, per axis

    axis_sample_if u_samp_if ();

    // input side
    current_sampler u_sampler (
        .clk          (clk),
        .rst          (rst),
        .cur_in       (cur_in),
        .cur_stb      (cur_stb),
        .dac_in       (dac_in),
        .dac_stb      (dac_stb),
        .axis_sel     (axis_sel),
        .enable_check (enable_check),
        .samp         (u_samp_if.source)
    );

    // compare and count
    current_safety_check u_check (
        .clk  (clk),
        .rst  (rst),
        .samp (u_samp_if.sink),
        .trip (trip)
    );

    // disable latches and first-fault
    amp_disable_ctrl u_disable (
        .clk               (clk),
        .rst               (rst),
        .trip              (trip),
        .clear_disable     (clear_disable),
        .amp_disable       (amp_disable),
        .any_disable       (any_disable),
        .first_fault       (first_fault),
        .first_fault_valid (first_fault_valid)
    );

endmodule

// ==== amp_disable_ctrl.sv ====
`include "safety_defs.svh"

module amp_disable_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`NUM_AXES-1:0]   trip,
    input  logic [`NUM_AXES-1:0]   clear_disable,
    output logic [`NUM_AXES-1:0]   amp_disable,
    output logic                   any_disable,
    output safety_pkg::axis_t      first_fault,
    output logic                   first_fault_valid
);

    logic [`NUM_AXES-1:0] dis_nxt;   // latch state after this edge
    logic [`NUM_AXES-1:0] set_mask;  // axes going 0 -> 1 this edge
    safety_pkg::axis_t    set_axis;  // lowest numbered setting axis

    // sticky latch, clear wins over trip
    assign dis_nxt  = (amp_disable | trip) & ~clear_disable;
    assign set_mask = dis_nxt & ~amp_disable;

    // priority encoder, walk down so the lowest index wins
    always_comb begin
        set_axis = '0;
        for (int i = `NUM_AXES - 1; i >= 0; i--) begin
            if (set_mask[i]) begin
                set_axis = safety_pkg::axis_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            amp_disable <= '0;
        end else begin
            amp_disable <= dis_nxt;
        end
    end

    // first fault capture
    always_ff @(posedge clk) begin
        if (rst) begin
            first_fault       <= '0;
            first_fault_valid <= 1'b0;
        end else if (!first_fault_valid) begin
            if (|set_mask) begin
                first_fault       <= set_axis;
                first_fault_valid <= 1'b1;
            end
        end else if (dis_nxt == '0) begin
            first_fault_valid <= 1'b0; // all released, rearm
        end
    end

    assign any_disable = |amp_disable;

endmodule

// ==== current_safety_check.sv ====
`include "safety_defs.svh"

module current_safety_check (
    input  logic                 clk,
    input  logic                 rst,
    axis_sample_if.sink          samp,
    output logic [`NUM_AXES-1:0] trip
);

    for (genvar a = 0; a < `NUM_AXES; a++) begin : g_axis

        safety_pkg::current_t cur;
        safety_pkg::current_t dac;
        safety_pkg::current_t diff;     // |cur - dac|
        safety_pkg::err_cnt_t err_cnt;
        logic                 active;   // enabled and both values present
        logic                 near_zero;
        logic                 cmd_large;
        logic                 over_margin;
        logic                 at_limit;

        assign cur = samp.cur[a];
        assign dac = samp.dac[a];

        assign active = samp.check_en[a] & samp.loaded[a];

        // measured current too small to judge
        assign near_zero = (cur > `CUR_ZERO_LO) && (cur < `CUR_ZERO_HI);

        // large command requested, nothing gained by checking
        assign cmd_large = (dac <= `CMD_LOW_EXEMPT) || (dac >= `CMD_HIGH_EXEMPT);

        // offset binary subtracts like unsigned, order the operands
        assign diff = (cur > dac) ? (cur - dac) : (dac - cur);
        assign over_margin = diff > `CUR_MARGIN;

        assign at_limit = err_cnt >= `ERR_LIMIT;

        // consecutive violation counter
        always_ff @(posedge clk) begin
            if (rst) begin
                err_cnt <= '0;
            end else if (!active) begin
                err_cnt <= '0;
            end else if (near_zero) begin
                err_cnt <= '0; // exemption 1
            end else if (cmd_large) begin
                err_cnt <= '0; // exemption 2
            end else if (over_margin) begin
                if (!at_limit) begin
                    err_cnt <= err_cnt + 1'b1;
                end // else hold, saturate at limit
            end else begin
                err_cnt <= '0; // back in band, streak broken
            end
        end

        assign trip[a] = at_limit; // straight off the counter

    end

endmodule

// ==== current_sampler.sv ====
`include "safety_defs.svh"

module current_sampler (
    input  logic                  clk,
    input  logic                  rst,
    input  safety_pkg::current_t  cur_in,
    input  logic                  cur_stb,
    input  safety_pkg::current_t  dac_in,
    input  logic                  dac_stb,
    input  safety_pkg::axis_t     axis_sel,     // applies to both strobes
    input  logic [`NUM_AXES-1:0]  enable_check,
    axis_sample_if.source         samp
);

    localparam safety_pkg::current_t CUR_MID = 16'h8000; // zero amps

    logic [`NUM_AXES-1:0] cur_seen; // measured value written at least once
    logic [`NUM_AXES-1:0] dac_seen; // command written at least once

    // sample holding regs, strobe never refused
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_AXES; i++) begin
                samp.cur[i] <= CUR_MID;
                samp.dac[i] <= CUR_MID;
            end
            cur_seen <= '0;
            dac_seen <= '0;
            samp.check_en <= '0;
        end else begin
            if (cur_stb) begin
                samp.cur[axis_sel] <= cur_in;
                cur_seen[axis_sel] <= 1'b1;
            end
            if (dac_stb) begin
                samp.dac[axis_sel] <= dac_in;
                dac_seen[axis_sel] <= 1'b1;
            end
            samp.check_en <= enable_check; // same 1-cycle delay as data
        end
    end

    // no check on reset values alone
    assign samp.loaded = cur_seen & dac_seen;

endmodule

// ==== axis_sample_if.sv ====
`include "safety_defs.svh"

// held samples, sampler -> checker
interface axis_sample_if;

    safety_pkg::current_t cur [`NUM_AXES]; // last measured current
    safety_pkg::current_t dac [`NUM_AXES]; // last commanded current
    logic [`NUM_AXES-1:0]  check_en;        // registered enable levels
    logic [`NUM_AXES-1:0]  loaded;          // both values seen since reset

    modport source (
        output cur, dac, check_en, loaded
    );

    modport sink (
        input cur, dac, check_en, loaded
    );

endinterface

// ==== safety_pkg.sv ====
`include "safety_defs.svh"

package safety_pkg;

    // offset binary, 0x8000 = zero current
    typedef logic [15:0] current_t;

    // axis number, sized from axis count
    typedef logic [$clog2(`NUM_AXES)-1:0] axis_t;

    // consecutive violation count
    typedef logic [`ERR_CNT_W-1:0] err_cnt_t;

endpackage

// ==== safety_defs.svh ====
`ifndef SAFETY_DEFS_SVH
`define SAFETY_DEFS_SVH

// number of supervised axes
`define NUM_AXES 4

// allowed |cmd - meas| before a cycle counts as violating, about 440 mA
`define CUR_MARGIN 16'h0900

// near-zero measured window, both bounds exclusive (roughly +/-150 mA)
`define CUR_ZERO_LO 16'h7D00
`define CUR_ZERO_HI 16'h8300

// command at or beyond these ends skips the check
`define CMD_LOW_EXEMPT  16'h0900
`define CMD_HIGH_EXEMPT 16'hF6FF

// consecutive violating cycles to trip, small value for sim
// (hardware value is 50 ms worth of clocks)
`define ERR_CNT_W 24
`define ERR_LIMIT 24'd5

`endif
